//--- verilog.f
+incdir+rtl
rtl/UsiBusPkg.sv
rtl/PeriphRegPkg.sv
rtl/UsiBusDecoder.sv
rtl/GpioBlock.sv
rtl/PwmBlock.sv
rtl/Processer.sv
bench/processer_properties.sv
bench/ProcesserTb.sv

//--- bench/ProcesserTb.sv
// Table-driven testbench for the Processer system-management block
// Expected values come from a register model updated on every bus write
// PWM settling allows for any earlier period up to 256 cycles
// Blink counts allow one toggle of slack at either end of the window
`timescale 1ns/1ps
`include "processer_consts.svh"

module ProcesserTb;

    localparam int opWrite = 0;
    localparam int opRead  = 1;
    localparam int opPins  = 2;
    localparam int opBlink = 3;
    localparam int opPwm   = 4;

    logic                sysClk;
    logic                rst;
    logic                busWrite;
    logic                busRead;
    UsiBusPkg::usiAddr_t busAddr;
    UsiBusPkg::usiData_t busWdata;
    UsiBusPkg::usiData_t busRdata;
    logic                busRvalid;
    logic [1:0]          ledEdge;
    logic                ledClk;
    logic                backLightControl;

    // Stimulus table, one queue per column
    int          opQ[$];
    logic [3:0]  addrQ[$];
    logic [31:0] dataQ[$];
    bit          dynQ[$];   // LCG data on writes, model value on reads
    logic [31:0] expQ[$];

    PeriphRegPkg::periphWord_u gpioModel;
    PeriphRegPkg::periphWord_u pwmModel;
    logic [31:0] lcgState = 32'h12ec;
    int          cycles   = 0;
    int          limit    = 0;
    int          errs     = 0;
    int          checks   = 0;
    bit          entryBad;

    Processer dut0 (
        .sysClk           (sysClk),
        .rst              (rst),
        .busWrite         (busWrite),
        .busRead          (busRead),
        .busAddr          (busAddr),
        .busWdata         (busWdata),
        .busRdata         (busRdata),
        .busRvalid        (busRvalid),
        .ledEdge          (ledEdge),
        .ledClk           (ledClk),
        .backLightControl (backLightControl)
    );

    // 40 ns clock
    always #20 sysClk = ~sysClk;

    // Watchdog on the summed entry budgets
    always @(posedge sysClk) begin
        cycles <= cycles + 1;
        if ((limit > 0) && (cycles >= limit)) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Simulation failed");
            $finish;
        end
    end

    //------------------------------
    // Helpers
    //------------------------------
    function logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function logic [31:0] gpioWord(input logic [11:0] div, input logic en,
                                   input logic lvl, input logic [1:0] edges);
        return {16'h0, div, en, lvl, edges};
    endfunction

    function logic [31:0] pwmWord(input logic en, input logic [7:0] duty,
                                  input logic [7:0] period);
        return {15'h0, period, duty, en};
    endfunction

    // Register rules: GPIO and PWM hold writes, ID fixed, rest zero
    function logic [31:0] modelRead(input logic [3:0] addr);
        case (addr)
            `ADDR_GPIO: return gpioModel;
            `ADDR_PWM:  return pwmModel;
            `ADDR_ID:   return `PROCESSER_ID;
            default:    return 32'h0;
        endcase
    endfunction

    // High cycles over four periods, min(duty, period+1) each
    function int pwmExpect();
        int p1;
        int highs;
        p1 = int'(pwmModel.pwm.period) + 1;
        highs = (int'(pwmModel.pwm.duty) < p1) ? int'(pwmModel.pwm.duty) : p1;
        return pwmModel.pwm.enable ? 4 * highs : 0;
    endfunction

    function int entryBudget(input int i);
        PeriphRegPkg::periphWord_u w;
        w = dataQ[i];
        case (opQ[i])
            opWrite: return 3;
            opRead:  return 12;
            opPins:  return 2;
            opBlink: return int'(expQ[i]) * (int'(w.gpio.blinkDiv) + 1) + 8;
            default: return 270 + 6 * (int'(w.pwm.period) + 1);
        endcase
    endfunction

    function string opName(input int op);
        case (op)
            opWrite: return "write";
            opRead:  return "read";
            opPins:  return "pins";
            opBlink: return "blink";
            default: return "measure pwm";
        endcase
    endfunction

    task checkVal(input string name, input logic [31:0] got, input logic [31:0] expVal);
        checks++;
        assert (got === expVal) else begin
            $display("FAILED %s got 0x%08h expected 0x%08h", name, got, expVal);
            errs++;
            entryBad = 1;
        end
    endtask

    task addEntry(input int op, input logic [3:0] addr, input logic [31:0] data,
                  input bit dyn, input logic [31:0] expVal);
        opQ.push_back(op);
        addrQ.push_back(addr);
        dataQ.push_back(data);
        dynQ.push_back(dyn);
        expQ.push_back(expVal);
    endtask

    //------------------------------
    // Bus access
    //------------------------------
    // One-cycle strobe, register updates at the sampling edge
    task writeBus(input logic [3:0] addr, input logic [31:0] data);
        @(posedge sysClk);
        busWrite <= 1'b1;
        busAddr  <= addr;
        busWdata <= data;
        @(posedge sysClk);
        busWrite <= 1'b0;
        if (addr == `ADDR_GPIO) begin
            gpioModel = data;
        end else if (addr == `ADDR_PWM) begin
            pwmModel = data;
        end
    endtask

    // Waits for busRvalid, bounded
    task readBus(input logic [3:0] addr, output logic [31:0] data, output bit valid);
        int waited;
        @(posedge sysClk);
        busRead <= 1'b1;
        busAddr <= addr;
        @(posedge sysClk);
        busRead <= 1'b0;
        waited = 0;
        @(negedge sysClk);
        while (!busRvalid && (waited < 8)) begin
            @(negedge sysClk);
            waited++;
        end
        valid = busRvalid;
        data  = busRdata;
        if (!valid) begin
            $display("No busRvalid pulse came after a read of address 0x%0h", addr);
            errs++;
            entryBad = 1;
        end
    endtask

    //------------------------------
    // Output measurement
    //------------------------------
    task countToggles(input int window, output int cnt);
        logic prev;
        cnt = 0;
        @(negedge sysClk);
        prev = ledClk;
        repeat (window) begin
            @(negedge sysClk);
            if (ledClk !== prev) begin
                cnt++;
            end
            prev = ledClk;
        end
    endtask

    // Longest old period, two new periods, then four measured
    task countPwmHighs(output int cnt);
        int p1;
        p1 = int'(pwmModel.pwm.period) + 1;
        cnt = 0;
        repeat (256 + 2 * p1) @(negedge sysClk);
        repeat (4 * p1) begin
            @(negedge sysClk);
            if (backLightControl === 1'b1) begin
                cnt++;
            end
        end
    endtask

    //------------------------------
    // Table and entry execution
    //------------------------------
    task buildTable();
        // Reset state
        addEntry(opPins,  `ADDR_GPIO, 32'h0, 0, 32'h0);
        addEntry(opRead,  `ADDR_GPIO, 32'h0, 0, 32'h0);
        addEntry(opRead,  `ADDR_PWM,  32'h0, 0, 32'h0);
        addEntry(opRead,  `ADDR_ID,   32'h0, 0, `PROCESSER_ID);
        // Random read-back, unmapped and read-only writes dropped
        addEntry(opWrite, `ADDR_GPIO, 32'h0, 1, 32'h0);
        addEntry(opPins,  `ADDR_GPIO, 32'h0, 0, 32'h0);
        addEntry(opRead,  `ADDR_GPIO, 32'h0, 1, 32'h0);
        addEntry(opWrite, `ADDR_PWM,  32'h0, 1, 32'h0);
        addEntry(opRead,  `ADDR_PWM,  32'h0, 1, 32'h0);
        addEntry(opWrite, 4'd7,       32'h0, 1, 32'h0);
        addEntry(opWrite, `ADDR_ID,   32'h0, 1, 32'h0);
        addEntry(opRead,  `ADDR_GPIO, 32'h0, 1, 32'h0);
        addEntry(opRead,  `ADDR_PWM,  32'h0, 1, 32'h0);
        addEntry(opRead,  4'd7,       32'h0, 0, 32'h0);
        addEntry(opRead,  4'hf,       32'h0, 0, 32'h0);
        addEntry(opRead,  `ADDR_ID,   32'h0, 0, `PROCESSER_ID);
        // LED pins in level mode
        addEntry(opWrite, `ADDR_GPIO, gpioWord(12'h000, 0, 1, 2'b10), 0, 32'h0);
        addEntry(opPins,  `ADDR_GPIO, 32'h0, 0, 32'h0);
        addEntry(opWrite, `ADDR_GPIO, gpioWord(12'h5a5, 0, 0, 2'b01), 0, 32'h0);
        addEntry(opPins,  `ADDR_GPIO, 32'h0, 0, 32'h0);
        // Blink mode, expected value is the toggle count
        addEntry(opBlink, `ADDR_GPIO, gpioWord(12'd3, 1, 0, 2'b11), 0, 32'd10);
        addEntry(opBlink, `ADDR_GPIO, gpioWord(12'd9, 1, 1, 2'b00), 0, 32'd6);
        addEntry(opWrite, `ADDR_GPIO, 32'h0, 0, 32'h0);
        addEntry(opPins,  `ADDR_GPIO, 32'h0, 0, 32'h0);
        // PWM duty and period pairs
        addEntry(opPwm,   `ADDR_PWM, pwmWord(1, 8'd3, 8'd9), 0, 32'h0);
        addEntry(opPwm,   `ADDR_PWM, pwmWord(1, 8'd16, 8'd15), 0, 32'h0);
        addEntry(opPwm,   `ADDR_PWM, pwmWord(1, 8'd200, 8'd4), 0, 32'h0);
        addEntry(opPwm,   `ADDR_PWM, pwmWord(1, 8'd0, 8'd7), 0, 32'h0);
        addEntry(opPwm,   `ADDR_PWM, pwmWord(1, 8'd1, 8'd0), 0, 32'h0);
        addEntry(opPwm,   `ADDR_PWM, pwmWord(0, 8'd5, 8'd9), 0, 32'h0);
        addEntry(opRead,  `ADDR_PWM, 32'h0, 1, 32'h0);
    endtask

    task runEntry(input int i);
        logic [31:0]               got;
        logic [31:0]               expVal;
        bit                        valid;
        int                        cnt;
        PeriphRegPkg::periphWord_u gotU;
        entryBad = 0;
        case (opQ[i])
            opWrite: begin
                writeBus(addrQ[i], dynQ[i] ? lcgNext() : dataQ[i]);
            end
            opRead: begin
                readBus(addrQ[i], got, valid);
                expVal = dynQ[i] ? modelRead(addrQ[i]) : expQ[i];
                if (valid) begin
                    gotU = got;
                    checkVal("busRdata", got, expVal);
                    // Fields at their register-map bit positions in each view
                    checkVal("busRdata.gpio.blinkDiv", gotU.gpio.blinkDiv, expVal[15:4]);
                    checkVal("busRdata.pwm.period", gotU.pwm.period, expVal[16:9]);
                end
            end
            opPins: begin
                @(negedge sysClk);
                checkVal("ledEdge", ledEdge, gpioModel.gpio.ledEdge);
                checkVal("ledClk", ledClk, gpioModel.gpio.ledClk);
                if (!pwmModel.pwm.enable) begin
                    checkVal("backLightControl", backLightControl, 32'h0);
                end
            end
            opBlink: begin
                writeBus(addrQ[i], dataQ[i]);
                countToggles(int'(expQ[i]) * (int'(gpioModel.gpio.blinkDiv) + 1), cnt);
                checks++;
                assert ((cnt >= int'(expQ[i]) - 1) && (cnt <= int'(expQ[i]) + 1)) else begin
                    $display("FAILED ledClk toggles got 0x%0h expected 0x%0h +/- 1",
                             cnt, expQ[i]);
                    errs++;
                    entryBad = 1;
                end
            end
            default: begin
                writeBus(addrQ[i], dataQ[i]);
                countPwmHighs(cnt);
                checkVal("backLightControl high cycles", cnt, pwmExpect());
            end
        endcase
        $display("entry %0d %s addr 0x%0h: %s", i, opName(opQ[i]), addrQ[i],
                 entryBad ? "mismatch" : "ok");
    endtask

    //------------------------------
    // Main sequence
    //------------------------------
    initial begin
        sysClk    = 1'b0;
        rst       = 1'b1;
        busWrite  = 1'b0;
        busRead   = 1'b0;
        busAddr   = '0;
        busWdata  = '0;
        gpioModel = '0;
        pwmModel  = '0;
        buildTable();
        // Reset cycles plus margin, then each entry's budget
        limit = 16 + 200;
        for (int i = 0; i < opQ.size(); i++) begin
            limit += entryBudget(i);
        end
        repeat (16) @(posedge sysClk);
        rst <= 1'b0;
        for (int i = 0; i < opQ.size(); i++) begin
            runEntry(i);
        end
        $display("Summary: %0d entries, %0d checks, %0d errors", opQ.size(), checks, errs);
        if (errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- bench/processer_properties.sv
// Concurrent checks on the Processer bus and board pins
// Bound into every Processer instance, sees its top-level ports
// PWM enable is taken from the PWM register word inside Processer
`timescale 1ns/1ps

module ProcesserProperties (
    input logic                      sysClk,
    input logic                      rst,
    input logic                      busRead,
    input logic                      busRvalid,
    input logic [1:0]                ledEdge,
    input logic                      backLightControl,
    input PeriphRegPkg::periphWord_u pwmReg
);

    //------------------------------
    // Read response
    //------------------------------
    // Valid follows a read strobe by exactly one cycle
    property rvalidAfterRead;
        @(posedge sysClk) disable iff (rst)
            busRead |=> busRvalid;
    endproperty

    // No valid pulse without a read one cycle earlier
    property noRvalidWithoutRead;
        @(posedge sysClk) disable iff (rst)
            !busRead |=> !busRvalid;
    endproperty

    //------------------------------
    // Backlight and reset state
    //------------------------------
    property backlightOffWhenDisabled;
        @(posedge sysClk) disable iff (rst)
            !pwmReg.pwm.enable |-> !backLightControl;
    endproperty

    // Outputs settle to zero after each reset edge
    property quietInReset;
        @(posedge sysClk)
            rst |=> (!busRvalid && (ledEdge == 2'b00) && !backLightControl);
    endproperty

    rvalidAfterReadA: assert property (rvalidAfterRead)
        else $error("busRvalid missing one cycle after busRead");
    noRvalidWithoutReadA: assert property (noRvalidWithoutRead)
        else $error("busRvalid high without a preceding busRead");
    backlightOffA: assert property (backlightOffWhenDisabled)
        else $error("backLightControl high while PWM enable is clear");
    quietInResetA: assert property (quietInReset)
        else $error("busRvalid, ledEdge or backLightControl not low in reset");

endmodule

bind Processer ProcesserProperties props0 (
    .sysClk           (sysClk),
    .rst              (rst),
    .busRead          (busRead),
    .busRvalid        (busRvalid),
    .ledEdge          (ledEdge),
    .backLightControl (backLightControl),
    .pwmReg           (pwmRegRd)
);

//--- rtl/Processer.sv
// System-management top level of the display board
// One clock domain, sysClk, with synchronous active-high rst
// Host drives the USI register bus directly, no handshake or back-pressure
// Register map: 0 GPIO, 1 PWM, 2 ID, the rest unmapped
`timescale 1ns/1ps

module Processer (
    input  logic                sysClk,
    input  logic                rst,
    // USI bus
    input  logic                busWrite,
    input  logic                busRead,
    input  UsiBusPkg::usiAddr_t busAddr,
    input  UsiBusPkg::usiData_t busWdata,
    output UsiBusPkg::usiData_t busRdata,
    output logic                busRvalid,
    // Board pins
    output logic [1:0]          ledEdge,
    output logic                ledClk,
    output logic                backLightControl
);

    logic                      gpioWe;
    logic                      pwmWe;
    PeriphRegPkg::periphWord_u wdata;
    PeriphRegPkg::periphWord_u gpioRegRd;
    PeriphRegPkg::periphWord_u pwmRegRd;
    logic                      pwmOut;

    //------------------------------
    // USI bus
    //------------------------------
    UsiBusDecoder busDec0 (
        .sysClk    (sysClk),
        .rst       (rst),
        .busWrite  (busWrite),
        .busRead   (busRead),
        .busAddr   (busAddr),
        .busWdata  (busWdata),
        .gpioRegRd (gpioRegRd),
        .pwmRegRd  (pwmRegRd),
        .gpioWe    (gpioWe),
        .pwmWe     (pwmWe),
        .wdata     (wdata),
        .busRdata  (busRdata),
        .busRvalid (busRvalid)
    );

    //------------------------------
    // LED block
    //------------------------------
    GpioBlock gpio0 (
        .sysClk  (sysClk),
        .rst     (rst),
        .we      (gpioWe),
        .wdata   (wdata),
        .regRd   (gpioRegRd),
        .ledEdge (ledEdge),
        .ledClk  (ledClk)
    );

    //------------------------------
    // PWM backlight
    //------------------------------
    PwmBlock pwm0 (
        .sysClk (sysClk),
        .rst    (rst),
        .we     (pwmWe),
        .wdata  (wdata),
        .regRd  (pwmRegRd),
        .pwmOut (pwmOut)
    );

    assign backLightControl = pwmOut;

endmodule

//--- rtl/PwmBlock.sv
// Backlight PWM with a period counter and shadowed duty and period
// Each period lasts period+1 cycles and starts high for min(duty, period+1)
// New duty and period take effect at the next period boundary
// Enable acts at once and forces the output low
`timescale 1ns/1ps
`include "processer_consts.svh"

module PwmBlock (
    input  logic                      sysClk,
    input  logic                      rst,
    input  logic                      we,
    input  PeriphRegPkg::periphWord_u wdata,
    output PeriphRegPkg::periphWord_u regRd,
    output logic                      pwmOut
);

    PeriphRegPkg::periphWord_u regQ;
    logic [7:0]                shDuty;
    logic [7:0]                shPeriod;
    logic [7:0]                cnt;
    logic                      wrap;

    //------------------------------
    // Host register
    //------------------------------
    always_ff @(posedge sysClk) begin
        if (rst) begin
            regQ <= `PWM_RST_VAL;
        end else if (we) begin
            regQ <= wdata;
        end
    end

    // Host sees what it wrote, not the shadow
    assign regRd = regQ;

    //------------------------------
    // Period counter
    //------------------------------
    // Last cycle of the current period
    assign wrap = (cnt == shPeriod);

    always_ff @(posedge sysClk) begin
        if (rst) begin
            cnt <= '0;
        end else if (wrap) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 8'd1;
        end
    end

    //------------------------------
    // Shadow copy
    //------------------------------
    // Loaded only at the boundary so no period is cut short
    always_ff @(posedge sysClk) begin
        if (rst) begin
            shDuty   <= '0;
            shPeriod <= '0;
        end else if (wrap) begin
            shDuty   <= regQ.pwm.duty;
            shPeriod <= regQ.pwm.period;
        end
    end

    //------------------------------
    // Output
    //------------------------------
    // Duty above period keeps it high the whole period
    assign pwmOut = regQ.pwm.enable && (cnt < shDuty);

endmodule

//--- rtl/GpioBlock.sv
// LED GPIO register and blink clock
// ledEdge and level-mode ledClk follow the register at the write edge
// Blink mode toggles ledClk every blinkDiv+1 cycles
// A write restarts the blink counter and reloads the ledClk level
`timescale 1ns/1ps
`include "processer_consts.svh"

module GpioBlock (
    input  logic                      sysClk,
    input  logic                      rst,
    input  logic                      we,
    input  PeriphRegPkg::periphWord_u wdata,
    output PeriphRegPkg::periphWord_u regRd,
    output logic [1:0]                ledEdge,
    output logic                      ledClk
);

    PeriphRegPkg::periphWord_u regQ;
    logic [11:0]               blinkCnt;
    logic                      blinkQ;

    //------------------------------
    // Host register
    //------------------------------
    always_ff @(posedge sysClk) begin
        if (rst) begin
            regQ <= `GPIO_RST_VAL;
        end else if (we) begin
            regQ <= wdata;
        end
    end

    // Whole word reads back, reserved bits included
    assign regRd = regQ;

    //------------------------------
    // Blink divider
    //------------------------------
    // Down-counter, toggle on underflow then reload
    always_ff @(posedge sysClk) begin
        if (rst) begin
            blinkCnt <= '0;
            blinkQ   <= 1'b0;
        end else if (we) begin
            // Start from the new divider and level
            blinkCnt <= wdata.gpio.blinkDiv;
            blinkQ   <= wdata.gpio.ledClk;
        end else if (regQ.gpio.blinkEn) begin
            if (blinkCnt == '0) begin
                blinkCnt <= regQ.gpio.blinkDiv;
                blinkQ   <= ~blinkQ;
            end else begin
                blinkCnt <= blinkCnt - 12'd1;
            end
        end
    end

    //------------------------------
    // LED pins
    //------------------------------
    assign ledEdge = regQ.gpio.ledEdge;
    // Level mode uses the stored bit directly
    assign ledClk  = regQ.gpio.blinkEn ? blinkQ : regQ.gpio.ledClk;

endmodule

//--- rtl/UsiBusDecoder.sv
// USI bus address decoder and read response register
// Strobes are single-cycle; busWrite and busRead are never high together
// Read data is registered and shows with busRvalid one cycle after busRead
// Unmapped addresses read 0 and their writes are dropped
`timescale 1ns/1ps
`include "processer_consts.svh"

module UsiBusDecoder (
    input  logic                      sysClk,
    input  logic                      rst,
    input  logic                      busWrite,
    input  logic                      busRead,
    input  UsiBusPkg::usiAddr_t       busAddr,
    input  UsiBusPkg::usiData_t       busWdata,
    input  PeriphRegPkg::periphWord_u gpioRegRd,
    input  PeriphRegPkg::periphWord_u pwmRegRd,
    output logic                      gpioWe,
    output logic                      pwmWe,
    output PeriphRegPkg::periphWord_u wdata,
    output UsiBusPkg::usiData_t       busRdata,
    output logic                      busRvalid
);

    UsiBusPkg::regSel_e  sel;
    UsiBusPkg::usiData_t rdMux;

    //------------------------------
    // Address decode
    //------------------------------
    // Only place in the design where the address is looked at
    always_comb begin
        case (busAddr)
            `ADDR_GPIO: sel = UsiBusPkg::selGpio;
            `ADDR_PWM:  sel = UsiBusPkg::selPwm;
            `ADDR_ID:   sel = UsiBusPkg::selId;
            default:    sel = UsiBusPkg::selNone;
        endcase
    end

    //------------------------------
    // Write path
    //------------------------------
    // One enable per block, shared data word
    assign gpioWe = busWrite && (sel == UsiBusPkg::selGpio);
    assign pwmWe  = busWrite && (sel == UsiBusPkg::selPwm);
    assign wdata  = busWdata;

    //------------------------------
    // Read path
    //------------------------------
    // ID is read-only, selNone gives zero
    always_comb begin
        case (sel)
            UsiBusPkg::selGpio: rdMux = gpioRegRd;
            UsiBusPkg::selPwm:  rdMux = pwmRegRd;
            UsiBusPkg::selId:   rdMux = `PROCESSER_ID;
            default:            rdMux = '0;
        endcase
    end

    // Valid is a one-cycle pulse, data holds until the next read
    always_ff @(posedge sysClk) begin
        if (rst) begin
            busRvalid <= 1'b0;
            busRdata  <= '0;
        end else begin
            busRvalid <= busRead;
            if (busRead) begin
                busRdata <= rdMux;
            end
        end
    end

endmodule

//--- rtl/PeriphRegPkg.sv
// Register layouts of the GPIO and PWM blocks
// Both layouts are exactly one 32-bit bus word
// Reserved bits are stored and read back but drive nothing

package PeriphRegPkg;

    //------------------------------
    // GPIO register, address 0
    //------------------------------
    // First member is the MSB end of the word
    typedef struct packed {
        logic [15:0] reserved;
        logic [11:0] blinkDiv;  // Half blink period minus one
        logic        blinkEn;
        logic        ledClk;    // Level used when blinkEn is clear
        logic [1:0]  ledEdge;
    } gpioReg_t;

    //------------------------------
    // PWM register, address 1
    //------------------------------
    typedef struct packed {
        logic [14:0] reserved;
        logic [7:0]  period;    // Period length minus one
        logic [7:0]  duty;      // High cycles per period
        logic        enable;
    } pwmReg_t;

    //------------------------------
    // One bus word, two readings
    //------------------------------
    // Address decides which member is meaningful
    typedef union packed {
        gpioReg_t gpio;
        pwmReg_t  pwm;
    } periphWord_u;

endpackage

//--- rtl/UsiBusPkg.sv
// Bus-side types of the USI register bus
// Address and data widths come from the shared constants header
// regSel_e is the decoded target of one address, selNone for unmapped
`include "processer_consts.svh"

package UsiBusPkg;

    //------------------------------
    // Raw bus words
    //------------------------------
    // Register address, one word per address
    typedef logic [`USI_ADDR_W-1:0] usiAddr_t;

    // Raw data word as seen on the bus pins
    typedef logic [`USI_DATA_W-1:0] usiData_t;

    //------------------------------
    // Decoded register target
    //------------------------------
    // selNone covers every unmapped address
    typedef enum logic [1:0] {
        selGpio,
        selPwm,
        selId,
        selNone
    } regSel_e;

endpackage

//--- rtl/processer_consts.svh
// Shared constants for the system-management block
// Widths are fixed by the register map and are not meant to be overridden
// Only addresses 0 to 2 are mapped; all others read 0 and ignore writes
`ifndef PROCESSER_CONSTS_SVH
`define PROCESSER_CONSTS_SVH

//------------------------------
// USI bus widths
//------------------------------
`define USI_ADDR_W      4
`define USI_DATA_W      32

//------------------------------
// Register addresses
//------------------------------
`define ADDR_GPIO       4'd0
`define ADDR_PWM        4'd1
`define ADDR_ID         4'd2

// Fixed word returned by an ID read
`define PROCESSER_ID    32'h5053_4d31

//------------------------------
// Register reset values
//------------------------------
`define GPIO_RST_VAL    32'h0000_0000
`define PWM_RST_VAL     32'h0000_0000

`endif
